//--- verilog/rf_link_cfg.svh
`ifndef RF_LINK_CFG_SVH
`define RF_LINK_CFG_SVH

// Bytes per received RF packet
`define RF_PKT_BYTES 3

// Bit period after reset, in clk cycles
`define RF_BIT_PERIOD_DEFAULT 16'd16

// Smallest period the SPI port accepts, smaller writes are raised to this
`define RF_BIT_PERIOD_MIN 16'd4

// Flops in each input synchronizer
`define RF_SYNC_STAGES 2

`endif

//--- verilog/rf_pkg.sv
package rf_pkg;

    // One sampled data bit from the RF line
    typedef struct packed {
        logic strobe;
        logic value;
        logic first;
    } rf_bit_t;

    // Received frame, b2 arrives first on the air
    typedef struct packed {
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;
    } rf_packet_t;

    // Bit period in clk cycles
    typedef logic [15:0] rf_period_t;

endpackage

//--- verilog/spi_pkg.sv
package spi_pkg;

    // First byte of every SPI transfer
    typedef enum logic [7:0] {
        READ_PKT   = 8'h01,
        SET_PERIOD = 8'h02,
        SEND_BYTE  = 8'h03
    } spi_cmd_e;

    // Byte returned ahead of the packet on READ_PKT
    typedef struct packed {
        logic [5:0] reserved;
        logic       tx_busy;
        logic       pkt_avail;
    } spi_status_t;

endpackage

//--- verilog/rf_bit_sampler.sv
`timescale 1ns/100ps
`include "rf_link_cfg.svh"

module rf_bit_sampler (
    input  logic               clk,
    input  logic               rst,
    input  logic               rfin,
    input  rf_pkg::rf_period_t period,
    output rf_pkg::rf_bit_t    bit_out
);

    localparam int DATA_BITS = `RF_PKT_BYTES * 8;
    localparam int BIT_CNT_W = $clog2(DATA_BITS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_GAP
    } state_e;

    logic [`RF_SYNC_STAGES-1:0] sync_q;
    logic                       rf_s;
    state_e                     state;
    rf_pkg::rf_period_t         cnt;
    logic [BIT_CNT_W-1:0]       bit_cnt;

    assign rf_s = sync_q[`RF_SYNC_STAGES-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_q  <= '1;
            state   <= S_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            bit_out <= '0;
        end else begin
            sync_q         <= {sync_q[`RF_SYNC_STAGES-2:0], rfin};
            bit_out.strobe <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Low level may be a start bit, check again at its center
                    if (!rf_s) begin
                        cnt   <= (period >> 1) - 16'd1;
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 16'd1;
                    end else if (rf_s) begin
                        state <= S_IDLE;
                    end else begin
                        cnt     <= period - 16'd1;
                        bit_cnt <= '0;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 16'd1;
                    end else begin
                        bit_out.strobe <= 1'b1;
                        bit_out.value  <= rf_s;
                        bit_out.first  <= (bit_cnt == '0);
                        bit_cnt        <= bit_cnt + 1'b1;
                        cnt            <= period - 16'd1;
                        if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
                            state <= S_GAP;
                        end
                    end
                end
                // Last bit may still be low, wait for the line to go idle
                S_GAP: begin
                    if (rf_s) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/packet_assembler.sv
`timescale 1ns/100ps
`include "rf_link_cfg.svh"

module packet_assembler (
    input  logic               clk,
    input  logic               rst,
    input  rf_pkg::rf_bit_t    bit_in,
    output rf_pkg::rf_packet_t pkt,
    output logic               pkt_valid,
    input  logic               pkt_ready
);

    localparam int PKT_BITS = `RF_PKT_BYTES * 8;
    localparam int CNT_W    = $clog2(PKT_BITS + 1);

    logic [PKT_BITS-1:0] shift_q;
    logic [PKT_BITS-1:0] shift_next;
    logic [CNT_W-1:0]    cnt;
    logic [CNT_W-1:0]    cnt_next;
    logic                frame_done;

    assign shift_next = {shift_q[PKT_BITS-2:0], bit_in.value};
    // First-bit flag resynchronizes the count to a new frame
    assign cnt_next   = bit_in.first ? CNT_W'(1) : cnt + 1'b1;
    assign frame_done = bit_in.strobe && (cnt_next == CNT_W'(PKT_BITS));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt       <= '0;
            pkt_valid <= 1'b0;
        end else begin
            if (bit_in.strobe) begin
                cnt <= frame_done ? '0 : cnt_next;
            end
            // A frame finishing while the last one is still pending is lost
            if (frame_done && !pkt_valid) begin
                pkt_valid <= 1'b1;
            end else if (pkt_valid && pkt_ready) begin
                pkt_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_in.strobe) begin
            shift_q <= shift_next;
        end
        if (frame_done && !pkt_valid) begin
            pkt <= rf_pkg::rf_packet_t'(shift_next);
        end
    end

endmodule

//--- verilog/hold_stage.sv
`timescale 1ns/100ps

module hold_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic     full_q;
    payload_t data_q;

    // Accepts a new entry in the same cycle the old one leaves
    assign in_ready  = !full_q || out_ready;
    assign out_valid = full_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            full_q <= 1'b1;
        end else if (out_ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

//--- verilog/spi_slave_port.sv
`timescale 1ns/100ps
`include "rf_link_cfg.svh"

module spi_slave_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               sck,
    input  logic               cs,
    input  logic               mosi,
    output logic               miso,
    input  rf_pkg::rf_packet_t pkt,
    input  logic               pkt_valid,
    output logic               pkt_ready,
    output logic [7:0]         tx_byte,
    output logic               tx_valid,
    input  logic               tx_ready,
    output rf_pkg::rf_period_t period
);

    typedef struct packed {
        logic sck;
        logic cs;
        logic mosi;
    } spi_pins_t;

    typedef enum logic [2:0] {
        C_CMD,
        C_READ,
        C_PER_HI,
        C_PER_LO,
        C_SEND,
        C_IGNORE
    } cmd_state_e;

    spi_pins_t               sync_q [`RF_SYNC_STAGES];
    spi_pins_t               pins;
    spi_pins_t               pins_d;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    cs_fall;
    logic [2:0]              bit_cnt;
    logic [7:0]              rx_shift;
    logic [7:0]              rx_byte;
    logic                    byte_done;
    logic [31:0]             tx_shift;
    logic                    miso_q;
    logic [7:0]              per_hi;
    rf_pkg::rf_period_t      per_new;
    cmd_state_e              state;
    spi_pkg::spi_status_t    status;

    assign pins      = sync_q[`RF_SYNC_STAGES-1];
    assign sck_rise  = pins.sck && !pins_d.sck;
    assign sck_fall  = !pins.sck && pins_d.sck;
    assign cs_fall   = !pins.cs && pins_d.cs;
    assign rx_byte   = {rx_shift[6:0], pins.mosi};
    assign byte_done = sck_rise && !pins.cs && (bit_cnt == 3'd7);
    assign per_new   = {per_hi, rx_byte};

    // Raw cs keeps miso quiet without waiting for the synchronizer
    assign miso = miso_q && !cs;

    always_comb begin
        status           = '0;
        status.pkt_avail = pkt_valid;
        status.tx_busy   = tx_valid || !tx_ready;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `RF_SYNC_STAGES; i++) begin
                sync_q[i] <= '{sck: 1'b0, cs: 1'b1, mosi: 1'b0};
            end
            pins_d    <= '{sck: 1'b0, cs: 1'b1, mosi: 1'b0};
            bit_cnt   <= '0;
            state     <= C_CMD;
            miso_q    <= 1'b0;
            pkt_ready <= 1'b0;
            tx_valid  <= 1'b0;
            period    <= `RF_BIT_PERIOD_DEFAULT;
        end else begin
            sync_q[0] <= '{sck: sck, cs: cs, mosi: mosi};
            for (int i = 1; i < `RF_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            pins_d    <= pins;
            pkt_ready <= 1'b0;
            if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0;
            end
            if (pins.cs || cs_fall) begin
                bit_cnt <= '0;
                state   <= C_CMD;
                miso_q  <= 1'b0;
            end else begin
                if (sck_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
                if (sck_fall) begin
                    miso_q <= tx_shift[31];
                end
                if (byte_done) begin
                    case (state)
                        C_CMD: begin
                            case (spi_pkg::spi_cmd_e'(rx_byte))
                                spi_pkg::READ_PKT: begin
                                    pkt_ready <= pkt_valid;
                                    state     <= C_READ;
                                end
                                spi_pkg::SET_PERIOD: state <= C_PER_HI;
                                spi_pkg::SEND_BYTE:  state <= C_SEND;
                                default:             state <= C_IGNORE;
                            endcase
                        end
                        C_PER_HI: state <= C_PER_LO;
                        C_PER_LO: begin
                            if (per_new < `RF_BIT_PERIOD_MIN) begin
                                period <= `RF_BIT_PERIOD_MIN;
                            end else begin
                                period <= per_new;
                            end
                            state <= C_IGNORE;
                        end
                        C_SEND: begin
                            // Hold stage full means the byte is dropped
                            if (tx_ready && !tx_valid) begin
                                tx_valid <= 1'b1;
                            end
                            state <= C_IGNORE;
                        end
                        default: state <= state;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_fall) begin
            tx_shift <= '0;
        end else if (byte_done && state == C_CMD &&
                     spi_pkg::spi_cmd_e'(rx_byte) == spi_pkg::READ_PKT) begin
            tx_shift <= {status, pkt_valid ? pkt : rf_pkg::rf_packet_t'('0)};
        end else if (sck_fall && !pins.cs) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
        if (sck_rise) begin
            rx_shift <= rx_byte;
        end
        if (byte_done && state == C_PER_HI) begin
            per_hi <= rx_byte;
        end
        if (byte_done && state == C_SEND && tx_ready && !tx_valid) begin
            tx_byte <= rx_byte;
        end
    end

endmodule

//--- verilog/tx_serializer.sv
`timescale 1ns/100ps

module tx_serializer (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         byte_in,
    input  logic               byte_valid,
    output logic               byte_ready,
    input  rf_pkg::rf_period_t period,
    output logic               line_out
);

    logic               busy_q;
    logic [8:0]         shift_q;
    logic [3:0]         bits_left;
    rf_pkg::rf_period_t cnt;
    rf_pkg::rf_period_t per_q;

    assign byte_ready = !busy_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q    <= 1'b0;
            line_out  <= 1'b1;
            bits_left <= '0;
            cnt       <= '0;
        end else if (!busy_q) begin
            // Start bit goes out the cycle after acceptance
            if (byte_valid) begin
                busy_q    <= 1'b1;
                line_out  <= 1'b0;
                bits_left <= 4'd9;
                cnt       <= period - 16'd1;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 16'd1;
        end else if (bits_left == '0) begin
            // Stop bit done, line already high
            busy_q <= 1'b0;
        end else begin
            line_out  <= shift_q[8];
            bits_left <= bits_left - 4'd1;
            cnt       <= per_q - 16'd1;
        end
    end

    // Data bits MSB first then the stop bit
    always_ff @(posedge clk) begin
        if (!busy_q && byte_valid) begin
            shift_q <= {byte_in, 1'b1};
            per_q   <= period;
        end else if (busy_q && cnt == '0 && bits_left != '0) begin
            shift_q <= {shift_q[7:0], 1'b1};
        end
    end

endmodule

//--- verilog/rf_link_top.sv
`timescale 1ns/100ps

module rf_link_top (
    input  logic clk,
    input  logic rst,
    input  logic rfin,
    input  logic sck,
    input  logic cs,
    input  logic mosi,
    input  logic tx_bypass,
    output logic miso,
    output logic tx_out,
    output logic pkt_rec
);

    rf_pkg::rf_bit_t    rx_bit;
    rf_pkg::rf_period_t period;
    rf_pkg::rf_packet_t asm_pkt;
    logic               asm_valid;
    logic               asm_ready;
    rf_pkg::rf_packet_t held_pkt;
    logic               held_ready;
    logic [7:0]         spi_tx_byte;
    logic               spi_tx_valid;
    logic               spi_tx_ready;
    logic [7:0]         ser_byte;
    logic               ser_valid;
    logic               ser_ready;
    logic               ser_line;

    assign tx_out = ser_line | tx_bypass;

    rf_bit_sampler i_sampler (
        .clk     (clk),
        .rst     (rst),
        .rfin    (rfin),
        .period  (period),
        .bit_out (rx_bit)
    );

    packet_assembler i_assembler (
        .clk       (clk),
        .rst       (rst),
        .bit_in    (rx_bit),
        .pkt       (asm_pkt),
        .pkt_valid (asm_valid),
        .pkt_ready (asm_ready)
    );

    // Receive side holds one full packet
    hold_stage #(.payload_t(rf_pkg::rf_packet_t)) i_pkt_hold (
        .clk       (clk),
        .rst       (rst),
        .in_data   (asm_pkt),
        .in_valid  (asm_valid),
        .in_ready  (asm_ready),
        .out_data  (held_pkt),
        .out_valid (pkt_rec),
        .out_ready (held_ready)
    );

    spi_slave_port i_spi (
        .clk       (clk),
        .rst       (rst),
        .sck       (sck),
        .cs        (cs),
        .mosi      (mosi),
        .miso      (miso),
        .pkt       (held_pkt),
        .pkt_valid (pkt_rec),
        .pkt_ready (held_ready),
        .tx_byte   (spi_tx_byte),
        .tx_valid  (spi_tx_valid),
        .tx_ready  (spi_tx_ready),
        .period    (period)
    );

    hold_stage #(.payload_t(logic [7:0])) i_tx_hold (
        .clk       (clk),
        .rst       (rst),
        .in_data   (spi_tx_byte),
        .in_valid  (spi_tx_valid),
        .in_ready  (spi_tx_ready),
        .out_data  (ser_byte),
        .out_valid (ser_valid),
        .out_ready (ser_ready)
    );

    tx_serializer i_serializer (
        .clk        (clk),
        .rst        (rst),
        .byte_in    (ser_byte),
        .byte_valid (ser_valid),
        .byte_ready (ser_ready),
        .period     (period),
        .line_out   (ser_line)
    );

endmodule

//--- testbench/rf_link_checker.sv
`timescale 1ns/100ps

module rf_link_checker (
    input logic clk,
    input logic rst,
    input logic cs,
    input logic miso,
    input logic tx_bypass,
    input logic tx_out,
    input logic pkt_rec
);

    int fail_count = 0;

    // Deselected slave keeps miso low
    a_miso_quiet: assert property (@(posedge clk) disable iff (!rst) cs |-> !miso)
        else begin
            fail_count++;
            $error("miso is high while cs is high");
        end

    a_bypass_high: assert property (@(posedge clk) disable iff (!rst) tx_bypass |-> tx_out)
        else begin
            fail_count++;
            $error("tx_out is low while tx_bypass is high");
        end

    // A packet only leaves through a READ_PKT, which needs cs low
    a_pkt_hold: assert property (@(posedge clk) disable iff (!rst) cs |-> !$fell(pkt_rec))
        else begin
            fail_count++;
            $error("pkt_rec fell while cs is high");
        end

endmodule

bind rf_link_top rf_link_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .cs        (cs),
    .miso      (miso),
    .tx_bypass (tx_bypass),
    .tx_out    (tx_out),
    .pkt_rec   (pkt_rec)
);

//--- testbench/rf_link_monitor.sv
`timescale 1ns/100ps
`include "rf_link_cfg.svh"

module rf_link_monitor (
    input logic clk,
    input logic rst,
    input logic rfin,
    input logic sck,
    input logic cs,
    input logic mosi,
    input logic miso,
    input logic tx_bypass,
    input logic tx_out,
    input logic pkt_rec
);

    localparam int DATA_BITS = `RF_PKT_BYTES * 8;

    string              test_name = "reset";
    int                 errors = 0;
    int                 tx_left = 0;
    rf_pkg::rf_period_t period = `RF_BIT_PERIOD_DEFAULT;
    rf_pkg::rf_packet_t pkt_q[$];
    logic [7:0]         tx_q[$];
    logic               tx_active = 1'b0;
    int                 tx_quiet = 0;
    logic               sck_d = 1'b0;
    logic               cs_d = 1'b1;
    logic [7:0]         mosi_sr;
    logic [7:0]         miso_sr;
    int                 bit_cnt = 0;
    int                 byte_idx = 0;
    logic [7:0]         cmd;
    logic [7:0]         resp [4];
    logic [7:0]         resp_mask;
    logic [7:0]         per_hi;

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s expected %02h actual %02h", test_name, what, exp, act);
        end
    endtask

    // Decodes one SPI byte of a transfer
    task automatic spi_byte(input logic [7:0] mo, input logic [7:0] mi);
        spi_pkg::spi_status_t st;
        rf_pkg::rf_packet_t   pk;
        rf_pkg::rf_period_t   np;
        logic [7:0]           mask;
        if (byte_idx == 0) begin
            cmd = mo;
            check_byte("miso during command", 8'h00, mi);
            if (mo == 8'(spi_pkg::READ_PKT)) begin
                st           = '0;
                st.pkt_avail = (pkt_q.size() > 0);
                pk           = '0;
                if (pkt_q.size() > 0) begin
                    pk = pkt_q.pop_front();
                end
                // tx_busy only predictable once the line has been quiet a while
                resp_mask = (tx_quiet >= int'(period) + 8) ? 8'hff : 8'hfd;
                resp[0]   = st;
                resp[1]   = pk.b2;
                resp[2]   = pk.b1;
                resp[3]   = pk.b0;
            end
        end else if (cmd == 8'(spi_pkg::READ_PKT)) begin
            if (byte_idx <= 4) begin
                mask = (byte_idx == 1) ? resp_mask : 8'hff;
                check_byte($sformatf("read byte %0d", byte_idx), resp[byte_idx-1] & mask,
                           mi & mask);
            end
        end else if (cmd == 8'(spi_pkg::SET_PERIOD)) begin
            if (byte_idx == 1) begin
                per_hi = mo;
            end else if (byte_idx == 2) begin
                np     = {per_hi, mo};
                period = (np < `RF_BIT_PERIOD_MIN) ? `RF_BIT_PERIOD_MIN : np;
            end
        end else if (cmd == 8'(spi_pkg::SEND_BYTE) && byte_idx == 1) begin
            tx_q.push_back(mo);
        end
        byte_idx++;
    endtask

    always @(posedge clk) begin
        if (tx_active || tx_q.size() > 0 || tx_out !== 1'b1) begin
            tx_quiet = 0;
        end else if (tx_quiet < 100000) begin
            tx_quiet++;
        end
        if (rst && tx_bypass && tx_out !== 1'b1) begin
            errors++;
            $display("Fail %s tx_out expected 1 actual %b", test_name, tx_out);
        end
        if (!cs && cs_d) begin
            if (pkt_rec !== (pkt_q.size() > 0)) begin
                errors++;
                $display("Fail %s pkt_rec expected %0d actual %0d", test_name,
                         pkt_q.size() > 0, pkt_rec);
            end
            bit_cnt  = 0;
            byte_idx = 0;
        end
        if (!cs && sck && !sck_d) begin
            mosi_sr = {mosi_sr[6:0], mosi};
            miso_sr = {miso_sr[6:0], miso};
            bit_cnt++;
            if (bit_cnt == 8) begin
                spi_byte(mosi_sr, miso_sr);
                bit_cnt = 0;
            end
        end
        sck_d   = sck;
        cs_d    = cs;
        tx_left = tx_q.size();
    end

    // RF frames sampled at each bit center
    initial begin
        rf_pkg::rf_period_t   p;
        logic [DATA_BITS-1:0] data;
        forever begin
            @(posedge clk);
            if (rst && rfin === 1'b0) begin
                p = period;
                repeat (p / 2) @(posedge clk);
                if (rfin === 1'b0) begin
                    for (int i = 0; i < DATA_BITS; i++) begin
                        repeat (p) @(posedge clk);
                        data = {data[DATA_BITS-2:0], rfin};
                    end
                    // Assembler plus hold stage keep two packets
                    if (pkt_q.size() < 2) begin
                        pkt_q.push_back(rf_pkg::rf_packet_t'(data));
                    end
                end
                while (rfin !== 1'b1) @(posedge clk);
            end
        end
    end

    // UART-like frames on tx_out
    initial begin
        rf_pkg::rf_period_t p;
        logic [9:0]         frame;
        logic [9:0]         byp;
        forever begin
            @(posedge clk);
            if (rst && !tx_bypass && tx_out === 1'b0) begin
                tx_active = 1'b1;
                p         = period;
                repeat (p / 2) @(posedge clk);
                frame[9] = tx_out;
                byp[9]   = tx_bypass;
                for (int i = 8; i >= 0; i--) begin
                    repeat (p) @(posedge clk);
                    frame[i] = tx_out;
                    byp[i]   = tx_bypass;
                end
                if (frame[9] !== 1'b0 || frame[0] !== 1'b1) begin
                    errors++;
                    $display("Fail %s tx_out start and stop expected 0 1 actual %b %b",
                             test_name, frame[9], frame[0]);
                end
                if (tx_q.size() == 0) begin
                    errors++;
                    $display("tx_out sent a frame in %s that nobody queued", test_name);
                end else begin
                    // Bypass forces a one onto every bit it covers
                    check_byte("tx_out byte", tx_q.pop_front() | byp[8:1], frame[8:1]);
                end
                tx_active = 1'b0;
            end
        end
    end

endmodule

//--- testbench/tb_rf_link.sv
`timescale 1ns/100ps

module tb_rf_link;

    localparam int          CLK_PERIOD_NS   = 20;
    localparam logic [31:0] SEED            = 32'hb4bf3b43;
    localparam int          NUM_TESTS       = 5;
    localparam int          FRAMES_PER_TEST = 10;
    localparam int          MAX_PERIOD      = 40;
    localparam int          SCK_HALF        = 5;
    localparam int TIMEOUT_NS = NUM_TESTS * FRAMES_PER_TEST * 30 * MAX_PERIOD * CLK_PERIOD_NS * 2;

    logic                 clk;
    logic                 rst;
    logic                 rfin;
    logic                 sck;
    logic                 cs;
    logic                 mosi;
    logic                 tx_bypass;
    logic                 miso;
    logic                 tx_out;
    logic                 pkt_rec;
    logic [31:0]          rng_state;
    int                   tb_errors;
    int                   cur_period;
    int                   total;
    logic [31:0]          r;
    spi_pkg::spi_status_t st;

    rf_link_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .rfin      (rfin),
        .sck       (sck),
        .cs        (cs),
        .mosi      (mosi),
        .tx_bypass (tx_bypass),
        .miso      (miso),
        .tx_out    (tx_out),
        .pkt_rec   (pkt_rec)
    );

    rf_link_monitor i_mon (
        .clk       (clk),
        .rst       (rst),
        .rfin      (rfin),
        .sck       (sck),
        .cs        (cs),
        .mosi      (mosi),
        .miso      (miso),
        .tx_bypass (tx_bypass),
        .tx_out    (tx_out),
        .pkt_rec   (pkt_rec)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Returns just after a rising edge so inputs never change on it
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic send_frame(input logic [23:0] data, input int per);
        rfin = 1'b0;
        wait_cycles(per);
        for (int i = 23; i >= 0; i--) begin
            rfin = data[i];
            wait_cycles(per);
        end
        rfin = 1'b1;
        wait_cycles(2 * per);
    endtask

    task automatic spi_transfer(input logic [39:0] out_bits, input int nbytes,
                                output logic [39:0] in_bits);
        in_bits = '0;
        cs      = 1'b0;
        for (int i = nbytes * 8 - 1; i >= 0; i--) begin
            mosi = out_bits[i];
            wait_cycles(SCK_HALF);
            sck        = 1'b1;
            in_bits[i] = miso;
            wait_cycles(SCK_HALF);
            sck = 1'b0;
        end
        wait_cycles(SCK_HALF);
        cs   = 1'b1;
        mosi = 1'b0;
        wait_cycles(2 * SCK_HALF);
    endtask

    task automatic read_packet(output spi_pkg::spi_status_t status);
        logic [39:0] rx;
        spi_transfer({8'(spi_pkg::READ_PKT), 32'h0}, 5, rx);
        status = rx[31:24];
    endtask

    task automatic set_period(input logic [15:0] val);
        logic [39:0] rx;
        spi_transfer({16'h0, 8'(spi_pkg::SET_PERIOD), val}, 3, rx);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [39:0] rx;
        spi_transfer({24'h0, 8'(spi_pkg::SEND_BYTE), b}, 2, rx);
    endtask

    task automatic wait_pkt_rec();
        int n;
        n = 0;
        while (pkt_rec !== 1'b1 && n < 8 * cur_period) begin
            wait_cycles(1);
            n++;
        end
        if (pkt_rec !== 1'b1) begin
            tb_errors++;
            $display("pkt_rec did not rise after a frame in %s", i_mon.test_name);
        end
    endtask

    task automatic wait_tx_idle();
        spi_pkg::spi_status_t s;
        int                   polls;
        polls = 0;
        read_packet(s);
        while (s.tx_busy && polls < 50) begin
            read_packet(s);
            polls++;
        end
        if (s.tx_busy) begin
            tb_errors++;
            $display("tx_busy never cleared in %s", i_mon.test_name);
        end
    endtask

    // Bypass covers data bits 7 to 5 of the next frame on tx_out
    task automatic bypass_during_frame();
        int n;
        n = 0;
        while (tx_out !== 1'b0 && n < 1000) begin
            wait_cycles(1);
            n++;
        end
        if (tx_out !== 1'b0) begin
            tb_errors++;
            $display("No frame started on tx_out in %s", i_mon.test_name);
        end else begin
            wait_cycles(cur_period);
            tx_bypass = 1'b1;
            wait_cycles(3 * cur_period);
            tx_bypass = 1'b0;
        end
    endtask

    task automatic frames_with_reads(input int n);
        logic [31:0] d;
        for (int i = 0; i < n; i++) begin
            d = next_random();
            send_frame(d[23:0], cur_period);
            wait_pkt_rec();
            read_packet(st);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b0;
        rfin       = 1'b1;
        sck        = 1'b0;
        cs         = 1'b1;
        mosi       = 1'b0;
        tx_bypass  = 1'b0;
        rng_state  = SEED;
        tb_errors  = 0;
        cur_period = 16;
        wait_cycles(5);
        rst = 1'b1;
        wait_cycles(5);

        i_mon.test_name = "random_packets";
        frames_with_reads(FRAMES_PER_TEST);

        i_mon.test_name = "empty_read";
        read_packet(st);

        // Third frame finds both stages full
        i_mon.test_name = "overflow";
        for (int i = 0; i < 3; i++) begin
            r = next_random();
            send_frame(r[23:0], cur_period);
        end
        wait_pkt_rec();
        for (int i = 0; i < 3; i++) begin
            read_packet(st);
        end

        i_mon.test_name = "period_change";
        r          = next_random();
        cur_period = 8 + int'(r % 32);
        set_period(16'(cur_period));
        frames_with_reads(3);
        set_period(16'd1);
        cur_period = 4;
        frames_with_reads(3);

        i_mon.test_name = "transmit";
        for (int i = 0; i < 4; i++) begin
            wait_tx_idle();
            r = next_random();
            send_byte(r[7:0]);
        end
        wait_tx_idle();
        wait_cycles(12 * cur_period);
        r          = next_random();
        cur_period = 8 + int'(r % 32);
        set_period(16'(cur_period));
        for (int i = 0; i < 4; i++) begin
            wait_tx_idle();
            r = next_random();
            send_byte(r[7:0]);
        end
        wait_tx_idle();
        wait_cycles(12 * cur_period);

        // Upper data bits are zero so only the bypass keeps the line high there
        r = next_random();
        fork
            send_byte(r[7:0] & 8'h0f);
            bypass_during_frame();
        join
        wait_tx_idle();
        wait_cycles(12 * cur_period);

        if (i_mon.tx_left != 0) begin
            tb_errors++;
            $display("%0d queued bytes never appeared on tx_out", i_mon.tx_left);
        end
        total = tb_errors + i_mon.errors + i_dut.i_checker.fail_count;
        $display("Errors: monitor %0d, assertions %0d, testbench %0d",
                 i_mon.errors, i_dut.i_checker.fail_count, tb_errors);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/rf_pkg.sv
verilog/spi_pkg.sv
verilog/rf_bit_sampler.sv
verilog/packet_assembler.sv
verilog/hold_stage.sv
verilog/spi_slave_port.sv
verilog/tx_serializer.sv
verilog/rf_link_top.sv
testbench/rf_link_checker.sv
testbench/rf_link_monitor.sv
testbench/tb_rf_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_rf_link -o tb_rf_link

output=$(./obj_dir/tb_rf_link +verilator+error+limit+1000)
echo "$output"

if grep -qx "TB PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
